// ==== src/g729_consts.svh ====
`ifndef G729_CONSTS_SVH
`define G729_CONSTS_SVH

////////////////////
// Subframe geometry
////////////////////

// Samples per 5 ms subframe
`define G729_L_SUBFR 40

// Scratch memory address bits, 4096 words
`define G729_ADDR_W 12

////////////////////
// Gain limits
////////////////////

// Pitch gain ceiling of 1.2 in Q14
`define G729_GAIN_MAX 16'sd19661

`endif

// ==== src/g729_types_pkg.sv ====
`default_nettype none

`include "g729_consts.svh"

package g729_types_pkg;

	// Q-format sample or gain
	typedef logic signed [15:0] word16_t;

	// Accumulator and scratch memory word
	typedef logic signed [31:0] word32_t;

	// Scratch memory address
	typedef logic [`G729_ADDR_W-1:0] mem_addr_t;

	// Normalization exponent that may go negative after the guard halving
	typedef logic signed [5:0] shift_t;

endpackage

`default_nettype wire

// ==== src/g_pitch_pkg.sv ====
`default_nettype none

package g_pitch_pkg;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		ACC,
		NORM,
		STORE,
		FINISH
	} pitch_state_t;

endpackage

`default_nettype wire

// ==== src/l_mac_sat.sv ====
`timescale 1ns/100ps
`default_nettype none

module l_mac_sat import g729_types_pkg::*; (
	input  word32_t i_acc,
	input  word16_t i_a,
	input  word16_t i_b,
	output word32_t o_sum
);

	word32_t            prod;
	word32_t            prod_x2;
	logic signed [32:0] sum_ext;

	assign prod = i_a * i_b;

	// Doubling -32768 * -32768 would wrap, so it clips
	assign prod_x2 = ((i_a == 16'sh8000) && (i_b == 16'sh8000)) ?
		32'sh7fff_ffff : (prod <<< 1);

	// One guard bit catches the overflow of the add
	assign sum_ext = {i_acc[31], i_acc} + {prod_x2[31], prod_x2};

	always_comb
	begin
		if (sum_ext[32] != sum_ext[31])
			o_sum = sum_ext[32] ? 32'sh8000_0000 : 32'sh7fff_ffff;
		else
			o_sum = sum_ext[31:0];
	end

endmodule

`default_nettype wire

// ==== src/norm_div.sv ====
`timescale 1ns/100ps
`default_nettype none

module norm_div import g729_types_pkg::*; (
	input  logic    clock,
	input  logic    i_rst,
	input  logic    i_start,
	input  word32_t i_num,
	input  word32_t i_den,
	output logic    o_done,
	output word16_t o_gain
);

	typedef enum logic [2:0] {
		ND_IDLE,
		ND_NORM,
		ND_HALVE,
		ND_DIV,
		ND_SHIFT
	} nd_state_t;

	nd_state_t   state;
	word32_t     num_r;
	word32_t     den_r;
	shift_t      exp_num;
	shift_t      exp_den;
	logic [15:0] div_den;
	logic [16:0] rem;
	logic [14:0] quo;
	logic [3:0]  iter;

	logic        num_ok;
	logic        den_ok;
	logic [16:0] rem_sh;
	shift_t      shift_amt;
	logic [5:0]  up_amt;
	logic [47:0] quo_up;
	word16_t     gain_next;

	// Normalized once bit 31 and bit 30 differ
	assign num_ok = (num_r[31] != num_r[30]) || (num_r == '0);
	assign den_ok = (den_r[31] != den_r[30]) || (den_r == '0);

	assign rem_sh = {rem[15:0], 1'b0};

	////////////////////
	// Output scaling
	////////////////////

	// Q15 quotient to Q14 gain
	assign shift_amt = exp_num - exp_den + 6'sd1;
	assign up_amt    = -shift_amt;
	assign quo_up    = {33'd0, quo} << up_amt;

	always_comb
	begin
		if (shift_amt > 6'sd15)
			gain_next = '0;
		else if (shift_amt >= 6'sd0)
			gain_next = {1'b0, quo >> shift_amt[3:0]};
		else if (quo_up > 48'd32767)
			gain_next = 16'sh7fff;
		else
			gain_next = quo_up[15:0];
	end

	////////////////////
	// Sequencer
	////////////////////

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			state  <= ND_IDLE;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				ND_IDLE:
				begin
					if (i_start && (i_num <= 0))
					begin
						o_gain <= '0;
						o_done <= 1'b1;
					end
					else if (i_start)
					begin
						num_r   <= i_num;
						den_r   <= i_den;
						exp_num <= '0;
						exp_den <= '0;
						state   <= ND_NORM;
					end
				end
				ND_NORM:
				begin
					// Both sums shift together, each stops on its own
					if (!num_ok)
					begin
						num_r   <= num_r << 1;
						exp_num <= exp_num + 6'sd1;
					end
					if (!den_ok)
					begin
						den_r   <= den_r << 1;
						exp_den <= exp_den + 6'sd1;
					end
					if (num_ok && den_ok)
						state <= ND_HALVE;
				end
				ND_HALVE:
				begin
					// div_s needs numerator below denominator
					if (num_r[31:16] >= den_r[31:16])
					begin
						rem     <= {2'b00, num_r[31:17]};
						exp_num <= exp_num - 6'sd1;
					end
					else
						rem <= {1'b0, num_r[31:16]};
					div_den <= den_r[31:16];
					quo     <= '0;
					iter    <= '0;
					state   <= ND_DIV;
				end
				ND_DIV:
				begin
					if (rem_sh >= {1'b0, div_den})
					begin
						rem <= rem_sh - {1'b0, div_den};
						quo <= {quo[13:0], 1'b1};
					end
					else
					begin
						rem <= rem_sh;
						quo <= {quo[13:0], 1'b0};
					end
					iter <= iter + 4'd1;
					if (iter == 4'd14)
						state <= ND_SHIFT;
				end
				ND_SHIFT:
				begin
					o_gain <= gain_next;
					o_done <= 1'b1;
					state  <= ND_IDLE;
				end
				default:
					state <= ND_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/g_pitch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "g729_consts.svh"

module g_pitch_ctrl import g729_types_pkg::*, g_pitch_pkg::*; (
	input  logic      clock,
	input  logic      i_rst,
	input  logic      i_start,
	input  mem_addr_t i_xn_base,
	input  mem_addr_t i_y1_base,
	input  mem_addr_t i_res_addr,
	output mem_addr_t o_rd_addr,
	input  word32_t   i_rd_data,
	output mem_addr_t o_wr_addr,
	output word32_t   o_wr_data,
	output logic      o_wr_en,
	output word32_t   o_mac_acc,
	output word16_t   o_mac_a,
	output word16_t   o_mac_b,
	input  word32_t   i_mac_sum,
	output logic      o_div_start,
	output word32_t   o_div_num,
	output word32_t   o_div_den,
	input  logic      i_div_done,
	input  word16_t   i_div_gain,
	output logic      o_done,
	output word16_t   o_gain
);

	pitch_state_t state;
	logic [5:0]   idx;
	word16_t      y1_r;
	word32_t      yy;
	word32_t      xy;
	word16_t      sample;
	word16_t      gain_lim;

	assign sample = i_rd_data[15:0];

	////////////////////
	// Memory and MAC steering
	////////////////////

	// READ fetches y1, ACC fetches xn, data lands one state later
	assign o_rd_addr = (state == ACC) ? (i_xn_base + mem_addr_t'(idx)) :
		(i_y1_base + mem_addr_t'(idx));

	// ACC squares y1, READ correlates the returning xn with held y1
	assign o_mac_acc = (state == ACC) ? yy : xy;
	assign o_mac_a   = sample;
	assign o_mac_b   = (state == ACC) ? sample : y1_r;

	assign o_div_num = xy;
	assign o_div_den = yy;
	assign o_wr_addr = i_res_addr;

	assign gain_lim = (i_div_gain > `G729_GAIN_MAX) ? `G729_GAIN_MAX : i_div_gain;

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			state       <= IDLE;
			o_wr_en     <= 1'b0;
			o_div_start <= 1'b0;
			o_done      <= 1'b0;
			o_gain      <= '0;
		end
		else
		begin
			o_wr_en     <= 1'b0;
			o_div_start <= 1'b0;
			o_done      <= 1'b0;
			case (state)
				IDLE:
				begin
					if (i_start)
					begin
						idx   <= '0;
						yy    <= 32'sd1;
						xy    <= '0;
						state <= READ;
					end
				end
				READ:
				begin
					// Nothing from xn has arrived yet on the first pass
					if (idx != '0)
						xy <= i_mac_sum;
					if (idx == 6'(`G729_L_SUBFR))
					begin
						o_div_start <= 1'b1;
						state       <= NORM;
					end
					else
						state <= ACC;
				end
				ACC:
				begin
					y1_r  <= sample;
					yy    <= i_mac_sum;
					idx   <= idx + 6'd1;
					state <= READ;
				end
				NORM:
				begin
					if (i_div_done)
					begin
						o_wr_data <= {{16{gain_lim[15]}}, gain_lim};
						o_wr_en   <= 1'b1;
						state     <= STORE;
					end
				end
				STORE:
				begin
					o_done <= 1'b1;
					o_gain <= o_wr_data[15:0];
					state  <= FINISH;
				end
				FINISH:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/pitch_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module pitch_cfg_regs import g729_types_pkg::*; (
	input  logic       clock,
	input  logic       i_rst,
	input  logic       i_cfg_we,
	input  logic [1:0] i_cfg_sel,
	input  mem_addr_t  i_cfg_data,
	output mem_addr_t  o_xn_base,
	output mem_addr_t  o_y1_base,
	output mem_addr_t  o_res_addr
);

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			// Default map keeps the three areas apart
			o_xn_base  <= mem_addr_t'(0);
			o_y1_base  <= mem_addr_t'(64);
			o_res_addr <= mem_addr_t'(128);
		end
		else if (i_cfg_we)
		begin
			case (i_cfg_sel)
				2'd0: o_xn_base  <= i_cfg_data;
				2'd1: o_y1_base  <= i_cfg_data;
				2'd2: o_res_addr <= i_cfg_data;
				// Code 3 is unused
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/scratch_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "g729_consts.svh"

module scratch_mem import g729_types_pkg::*; (
	input  logic      clock,
	input  logic      i_test_sel,
	input  mem_addr_t i_core_wr_addr,
	input  word32_t   i_core_wr_data,
	input  logic      i_core_wr_en,
	input  mem_addr_t i_core_rd_addr,
	input  mem_addr_t i_test_wr_addr,
	input  word32_t   i_test_wr_data,
	input  logic      i_test_wr_en,
	input  mem_addr_t i_test_rd_addr,
	output word32_t   o_rdata
);

	localparam int mem_depth = 1 << `G729_ADDR_W;

	word32_t   mem [mem_depth];
	mem_addr_t wr_addr;
	word32_t   wr_data;
	logic      wr_en;
	mem_addr_t rd_addr;

	// Test port takes both ports at once
	always_comb
	begin
		if (i_test_sel)
		begin
			wr_addr = i_test_wr_addr;
			wr_data = i_test_wr_data;
			wr_en   = i_test_wr_en;
			rd_addr = i_test_rd_addr;
		end
		else
		begin
			wr_addr = i_core_wr_addr;
			wr_data = i_core_wr_data;
			wr_en   = i_core_wr_en;
			rd_addr = i_core_rd_addr;
		end
	end

	always_ff @(posedge clock)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered read for block RAM
	always_ff @(posedge clock)
	begin
		o_rdata <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== src/g_pitch_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module g_pitch_pipe import g729_types_pkg::*; (
	input  logic       clock,
	input  logic       i_rst,
	input  logic       i_start,
	output logic       o_done,
	output word16_t    o_gain,
	input  logic       i_cfg_we,
	input  logic [1:0] i_cfg_sel,
	input  mem_addr_t  i_cfg_data,
	input  logic       i_test_sel,
	input  mem_addr_t  i_test_wr_addr,
	input  word32_t    i_test_wr_data,
	input  logic       i_test_wr_en,
	input  mem_addr_t  i_test_rd_addr,
	output word32_t    o_rdata
);

	mem_addr_t xn_base;
	mem_addr_t y1_base;
	mem_addr_t res_addr;
	mem_addr_t rd_addr;
	mem_addr_t wr_addr;
	word32_t   wr_data;
	logic      wr_en;

	word32_t   mac_acc;
	word16_t   mac_a;
	word16_t   mac_b;
	word32_t   mac_sum;

	logic      div_start;
	word32_t   div_num;
	word32_t   div_den;
	logic      div_done;
	word16_t   div_gain;

	pitch_cfg_regs pitch_cfg_regs_i (
		.clock      (clock),
		.i_rst      (i_rst),
		.i_cfg_we   (i_cfg_we),
		.i_cfg_sel  (i_cfg_sel),
		.i_cfg_data (i_cfg_data),
		.o_xn_base  (xn_base),
		.o_y1_base  (y1_base),
		.o_res_addr (res_addr)
	);

	// Read data feeds the controller and the test port alike
	g_pitch_ctrl g_pitch_ctrl_i (
		.clock       (clock),
		.i_rst       (i_rst),
		.i_start     (i_start),
		.i_xn_base   (xn_base),
		.i_y1_base   (y1_base),
		.i_res_addr  (res_addr),
		.o_rd_addr   (rd_addr),
		.i_rd_data   (o_rdata),
		.o_wr_addr   (wr_addr),
		.o_wr_data   (wr_data),
		.o_wr_en     (wr_en),
		.o_mac_acc   (mac_acc),
		.o_mac_a     (mac_a),
		.o_mac_b     (mac_b),
		.i_mac_sum   (mac_sum),
		.o_div_start (div_start),
		.o_div_num   (div_num),
		.o_div_den   (div_den),
		.i_div_done  (div_done),
		.i_div_gain  (div_gain),
		.o_done      (o_done),
		.o_gain      (o_gain)
	);

	l_mac_sat l_mac_sat_i (
		.i_acc (mac_acc),
		.i_a   (mac_a),
		.i_b   (mac_b),
		.o_sum (mac_sum)
	);

	norm_div norm_div_i (
		.clock   (clock),
		.i_rst   (i_rst),
		.i_start (div_start),
		.i_num   (div_num),
		.i_den   (div_den),
		.o_done  (div_done),
		.o_gain  (div_gain)
	);

	scratch_mem scratch_mem_i (
		.clock          (clock),
		.i_test_sel     (i_test_sel),
		.i_core_wr_addr (wr_addr),
		.i_core_wr_data (wr_data),
		.i_core_wr_en   (wr_en),
		.i_core_rd_addr (rd_addr),
		.i_test_wr_addr (i_test_wr_addr),
		.i_test_wr_data (i_test_wr_data),
		.i_test_wr_en   (i_test_wr_en),
		.i_test_rd_addr (i_test_rd_addr),
		.o_rdata        (o_rdata)
	);

endmodule

`default_nettype wire

// ==== sim/tb_g_pitch_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "g729_consts.svh"

module tb_g_pitch_pipe import g729_types_pkg::*;;

	localparam int run_count      = 10;
	localparam int run_cycles     = 200;
	localparam int load_cycles    = 4 * `G729_L_SUBFR;
	localparam int timeout_cycles = 16 + 100 + run_count * (run_cycles + load_cycles) +
		run_cycles;

	logic       clock = 1'b0;
	logic       i_rst;
	logic       i_start;
	logic       o_done;
	word16_t    o_gain;
	logic       i_cfg_we;
	logic [1:0] i_cfg_sel;
	mem_addr_t  i_cfg_data;
	logic       i_test_sel;
	mem_addr_t  i_test_wr_addr;
	word32_t    i_test_wr_data;
	logic       i_test_wr_en;
	mem_addr_t  i_test_rd_addr;
	word32_t    o_rdata;

	// Vectors of the current run and where they live
	word16_t     xn_v [`G729_L_SUBFR];
	word16_t     y1_v [`G729_L_SUBFR];
	mem_addr_t   xn_base;
	mem_addr_t   y1_base;
	mem_addr_t   res_addr;
	logic [31:0] rng_state;
	int          error_count;
	int          cycle_count = 0;

	always #4 clock = ~clock;

	g_pitch_pipe g_pitch_pipe_i (
		.clock          (clock),
		.i_rst          (i_rst),
		.i_start        (i_start),
		.o_done         (o_done),
		.o_gain         (o_gain),
		.i_cfg_we       (i_cfg_we),
		.i_cfg_sel      (i_cfg_sel),
		.i_cfg_data     (i_cfg_data),
		.i_test_sel     (i_test_sel),
		.i_test_wr_addr (i_test_wr_addr),
		.i_test_wr_data (i_test_wr_data),
		.i_test_wr_en   (i_test_wr_en),
		.i_test_rd_addr (i_test_rd_addr),
		.o_rdata        (o_rdata)
	);

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_cycles)
		begin
			$display("Timeout: the run did not end within %0d cycles", timeout_cycles);
			$display("TB FAILED");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Random sample with a random magnitude range
	function automatic word16_t rand_sample();
		rng_state = xorshift32(rng_state);
		return $signed(rng_state[15:0]) >>> rng_state[19:18];
	endfunction

	function automatic word32_t mac_ref(input word32_t acc, input word16_t a, input word16_t b);
		longint p;
		longint s;
		p = 2 * longint'(a) * longint'(b);
		if (p > 64'sd2147483647)
			p = 2147483647;
		s = longint'(acc) + p;
		if (s > 64'sd2147483647)
			s = 2147483647;
		else if (s < -64'sd2147483648)
			s = -2147483648;
		return s[31:0];
	endfunction

	// Left shifts that bring a positive sum to bit 30
	function automatic int norm_exp(input word32_t v);
		int      e;
		word32_t t;
		e = 0;
		t = v;
		while (t[31] == t[30])
		begin
			t = t << 1;
			e = e + 1;
		end
		return e;
	endfunction

	function automatic word16_t gain_ref();
		word32_t     xy;
		word32_t     yy;
		word32_t     n;
		word32_t     d;
		logic [15:0] nh;
		logic [15:0] dh;
		int          en;
		int          ed;
		int          sh;
		int          i;
		longint      q;
		longint      g;
		xy = 0;
		yy = 1;
		for (i = 0; i < `G729_L_SUBFR; i++)
		begin
			yy = mac_ref(yy, y1_v[i], y1_v[i]);
			xy = mac_ref(xy, xn_v[i], y1_v[i]);
		end
		if (xy <= 0)
			return 16'sd0;
		en = norm_exp(xy);
		ed = norm_exp(yy);
		n  = xy <<< en;
		d  = yy <<< ed;
		nh = n[31:16];
		dh = d[31:16];
		if (nh >= dh)
		begin
			nh = nh >> 1;
			en = en - 1;
		end
		// Q15 quotient, then Q14 scaling by the exponent difference
		q  = (longint'(nh) * 32768) / longint'(dh);
		sh = en - ed + 1;
		if (sh > 15)
			g = 0;
		else if (sh >= 0)
			g = q >> sh;
		else
		begin
			g = q << (-sh);
			if (g > 32767)
				g = 32767;
		end
		if (g > `G729_GAIN_MAX)
			g = `G729_GAIN_MAX;
		return word16_t'(g);
	endfunction

	////////////////////
	// Bus tasks
	////////////////////

	task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected)
		begin
			error_count = error_count + 1;
			$display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what,
				$signed(got), $signed(expected));
			$display("TB FAILED");
			$fatal(1, "Stopping on the first error");
		end
	endtask

	task automatic mem_write(input mem_addr_t addr, input word32_t data);
		i_test_wr_addr = addr;
		i_test_wr_data = data;
		i_test_wr_en   = 1'b1;
		@(negedge clock);
		i_test_wr_en = 1'b0;
	endtask

	// Data comes back one cycle after the address
	task automatic mem_read(input mem_addr_t addr, output word32_t data);
		i_test_rd_addr = addr;
		@(negedge clock);
		data = o_rdata;
	endtask

	task automatic cfg_write(input logic [1:0] sel, input mem_addr_t data);
		i_cfg_we   = 1'b1;
		i_cfg_sel  = sel;
		i_cfg_data = data;
		@(negedge clock);
		i_cfg_we = 1'b0;
	endtask

	task automatic load_vectors();
		int i;
		i_test_sel = 1'b1;
		for (i = 0; i < `G729_L_SUBFR; i++)
		begin
			mem_write(xn_base + mem_addr_t'(i), word32_t'(xn_v[i]));
			mem_write(y1_base + mem_addr_t'(i), word32_t'(y1_v[i]));
		end
		i_test_sel = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!o_done)
		begin
			@(negedge clock);
			n = n + 1;
			if (n > run_cycles)
			begin
				$display("Error: no done pulse within %0d cycles of start", run_cycles);
				$display("TB FAILED");
				$fatal(1, "The core did not finish");
			end
		end
	endtask

	task automatic run_and_check(input string what);
		word16_t expected;
		word32_t stored;
		expected = gain_ref();
		i_start  = 1'b1;
		@(negedge clock);
		i_start = 1'b0;
		wait_done();
		check_equal(o_gain, expected, {what, " gain"});
		i_test_sel = 1'b1;
		mem_read(res_addr, stored);
		i_test_sel = 1'b0;
		check_equal(stored, word32_t'(expected), {what, " stored result"});
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic mem_port_roundtrip();
		word32_t data [16];
		word32_t got;
		int      i;
		i_test_sel = 1'b1;
		for (i = 0; i < 16; i++)
		begin
			rng_state = xorshift32(rng_state);
			data[i]   = rng_state;
			mem_write(mem_addr_t'(12'hff0 + i), data[i]);
		end
		for (i = 0; i < 16; i++)
		begin
			mem_read(mem_addr_t'(12'hff0 + i), got);
			check_equal(got, data[i], "test port readback");
		end
		i_test_sel = 1'b0;
	endtask

	task automatic random_vector_runs();
		int p;
		int i;
		for (p = 0; p < 5; p++)
		begin
			// Scaled copy of y1 plus noise keeps the correlation mostly positive
			for (i = 0; i < `G729_L_SUBFR; i++)
			begin
				y1_v[i] = rand_sample();
				xn_v[i] = (y1_v[i] >>> (p % 3)) + (rand_sample() >>> 6);
			end
			load_vectors();
			run_and_check($sformatf("random pair %0d", p));
		end
	endtask

	task automatic negative_corr_run();
		int i;
		for (i = 0; i < `G729_L_SUBFR; i++)
		begin
			y1_v[i] = rand_sample() >>> 1;
			xn_v[i] = -y1_v[i];
		end
		load_vectors();
		run_and_check("negative correlation");
		check_equal(o_gain, 16'sd0, "negative correlation zero gain");
	endtask

	task automatic large_gain_runs();
		int i;
		for (i = 0; i < `G729_L_SUBFR; i++)
		begin
			y1_v[i] = rand_sample() >>> 4;
			xn_v[i] = y1_v[i] <<< 2;
		end
		load_vectors();
		run_and_check("gain of four");
		check_equal(o_gain, `G729_GAIN_MAX, "gain limit");
		for (i = 0; i < `G729_L_SUBFR; i++)
		begin
			y1_v[i] = (rand_sample() >>> 4) & 16'shfffe;
			xn_v[i] = y1_v[i] >>> 1;
		end
		load_vectors();
		run_and_check("gain of one half");
		check_equal((o_gain >= 16'sd8190) && (o_gain <= 16'sd8192), 1'b1, "half gain range");
	endtask

	task automatic moved_bases_run();
		word32_t marker;
		word32_t got;
		int      i;
		// Decoys at the reset addresses would give a zero gain
		for (i = 0; i < `G729_L_SUBFR; i++)
		begin
			y1_v[i] = rand_sample() >>> 1;
			xn_v[i] = -y1_v[i];
		end
		load_vectors();
		// Marker word at the old result address, no gain can look like it
		marker     = 32'h5a5a_0f0f;
		i_test_sel = 1'b1;
		mem_write(res_addr, marker);
		i_test_sel = 1'b0;
		xn_base  = 12'd1536;
		y1_base  = 12'd2560;
		res_addr = 12'd3000;
		cfg_write(2'd0, xn_base);
		cfg_write(2'd1, y1_base);
		cfg_write(2'd2, res_addr);
		for (i = 0; i < `G729_L_SUBFR; i++)
		begin
			y1_v[i] = rand_sample();
			xn_v[i] = (y1_v[i] >>> 1) + (rand_sample() >>> 8);
		end
		load_vectors();
		run_and_check("new base addresses");
		check_equal(o_gain != 16'sd0, 1'b1, "gain from the new vectors");
		i_test_sel = 1'b1;
		mem_read(12'd128, got);
		i_test_sel = 1'b0;
		check_equal(got, marker, "old result address untouched");
	endtask

	task automatic saturation_restart_run();
		word16_t expected;
		int      dones;
		int      n;
		int      i;
		for (i = 0; i < `G729_L_SUBFR; i++)
		begin
			xn_v[i] = 16'sh8000;
			y1_v[i] = 16'sh8000;
		end
		load_vectors();
		expected = gain_ref();
		dones    = 0;
		i_start  = 1'b1;
		@(negedge clock);
		// Second start lands in the middle of the accumulation
		// Window covers two runs so a queued restart would show
		for (n = 0; n < 2 * run_cycles; n++)
		begin
			i_start = (n == 20);
			if (o_done)
			begin
				dones = dones + 1;
				check_equal(o_gain, expected, "saturated gain");
			end
			@(negedge clock);
		end
		i_start = 1'b0;
		check_equal(dones, 1, "done pulses with a repeated start");
	endtask

	initial
	begin
		i_rst          = 1'b1;
		i_start        = 1'b0;
		i_cfg_we       = 1'b0;
		i_cfg_sel      = 2'd0;
		i_cfg_data     = '0;
		i_test_sel     = 1'b0;
		i_test_wr_addr = '0;
		i_test_wr_data = '0;
		i_test_wr_en   = 1'b0;
		i_test_rd_addr = '0;
		rng_state      = 32'hca1e_f56a;
		error_count    = 0;
		xn_base        = 12'd0;
		y1_base        = 12'd64;
		res_addr       = 12'd128;
		repeat (16) @(negedge clock);
		i_rst = 1'b0;
		@(negedge clock);
		check_equal(o_done, 1'b0, "done after reset");
		check_equal(o_gain, 16'sd0, "gain after reset");
		mem_port_roundtrip();
		random_vector_runs();
		negative_corr_run();
		large_gain_runs();
		moved_bases_run();
		saturation_restart_run();
		if (error_count == 0)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
		begin
			$display("TB FAILED");
			$fatal(1, "Checks failed");
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/g729_types_pkg.sv
src/g_pitch_pkg.sv
src/l_mac_sat.sv
src/norm_div.sv
src/g_pitch_ctrl.sv
src/pitch_cfg_regs.sv
src/scratch_mem.sv
src/g_pitch_pipe.sv
sim/tb_g_pitch_pipe.sv

// ==== Bender.yml ====
package:
  name: g_pitch_pipe

sources:
  - include_dirs:
      - src
    files:
      - src/g729_types_pkg.sv
      - src/g_pitch_pkg.sv
      - src/l_mac_sat.sv
      - src/norm_div.sv
      - src/g_pitch_ctrl.sv
      - src/pitch_cfg_regs.sv
      - src/scratch_mem.sv
      - src/g_pitch_pipe.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_g_pitch_pipe.sv
